/* exu_pkg.sv */
`default_nettype none

package exu_pkg;

    // datapath and tag widths
    localparam int unsigned XLEN            = 32;
    localparam int unsigned REG_ADDR_WIDTH  = 5;
    localparam int unsigned COMMIT_ID_WIDTH = 4;
    localparam int unsigned SHAMT_WIDTH     = $clog2(XLEN);

    // one shift-subtract step per dividend bit
    localparam int unsigned DIV_ITER      = XLEN;
    localparam int unsigned DIV_CNT_WIDTH = $clog2(DIV_ITER + 1);

    typedef logic [DIV_CNT_WIDTH-1:0] div_cnt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        DIV_DIV,
        DIV_DIVU,
        DIV_REM,
        DIV_REMU
    } div_op_e;

    // record handed to the writeback stage, 41 bits
    typedef struct packed {
        logic [XLEN-1:0]            wdata;
        logic [REG_ADDR_WIDTH-1:0]  waddr;
        logic [COMMIT_ID_WIDTH-1:0] commit_id;
    } wb_t;

endpackage

`default_nettype wire

/* exu_result_if.sv */
`default_nettype none

interface exu_result_if (
    input logic clk
);
    logic         valid;
    exu_pkg::wb_t data;
    logic         accept;

    // result producer, holds valid and data until accept
    modport unit (
        input  clk,
        output valid,
        output data,
        input  accept
    );

    modport arb (
        input  clk,
        input  valid,
        input  data,
        output accept
    );
endinterface

`default_nettype wire

/* exu_alu.sv */
`default_nettype none

module exu_alu (
    input  logic                                   clk,
    input  logic                                   arst_n_i,
    input  logic                                   flush_i,
    input  logic                                   req_i,
    input  exu_pkg::alu_op_e                       op_i,
    input  logic [exu_pkg::XLEN-1:0]               op1_i,
    input  logic [exu_pkg::XLEN-1:0]               op2_i,
    input  logic [exu_pkg::REG_ADDR_WIDTH-1:0]     rd_i,
    input  logic [exu_pkg::COMMIT_ID_WIDTH-1:0]    commit_id_i,
    output logic                                   ready_o,
    exu_result_if.unit                             res
);
    logic [exu_pkg::XLEN-1:0]        result;
    logic [exu_pkg::SHAMT_WIDTH-1:0] shamt;
    logic                            take;
    logic                            slot_valid_q;
    exu_pkg::wb_t                    slot_q;

    assign shamt = op2_i[exu_pkg::SHAMT_WIDTH-1:0];

    always_comb begin
        result = '0;
        unique case (op_i)
            exu_pkg::ALU_ADD:  result = op1_i + op2_i;
            exu_pkg::ALU_SUB:  result = op1_i - op2_i;
            exu_pkg::ALU_AND:  result = op1_i & op2_i;
            exu_pkg::ALU_OR:   result = op1_i | op2_i;
            exu_pkg::ALU_XOR:  result = op1_i ^ op2_i;
            exu_pkg::ALU_SLL:  result = op1_i << shamt;
            exu_pkg::ALU_SRL:  result = op1_i >> shamt;
            exu_pkg::ALU_SRA:  result = $signed(op1_i) >>> shamt;
            exu_pkg::ALU_SLT:  result[0] = $signed(op1_i) < $signed(op2_i);
            exu_pkg::ALU_SLTU: result[0] = op1_i < op2_i;
            default:           result = '0;
        endcase
    end

    // slot empty means a new request can go in
    assign ready_o = !slot_valid_q;
    assign take    = req_i && ready_o && !flush_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_valid_q <= 1'b0;
        end else if (flush_i) begin
            slot_valid_q <= 1'b0;
        end else if (take) begin
            slot_valid_q <= 1'b1;
        end else if (res.accept) begin
            slot_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            slot_q <= {result, rd_i, commit_id_i};
        end
    end

    assign res.valid = slot_valid_q;
    assign res.data  = slot_q;

endmodule

`default_nettype wire

/* exu_div_fsm.sv */
`default_nettype none

module exu_div_fsm (
    input  logic clk,
    input  logic arst_n_i,
    input  logic flush_i,
    input  logic req_i,
    output logic ready_o,
    output logic load_o,
    output logic step_o,
    output logic fix_o,
    output logic res_valid_o,
    input  logic res_accept_i
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_DIVIDE,
        S_FIX,
        S_DONE
    } state_e;

    state_e              state_q;
    state_e              state_d;
    exu_pkg::div_cnt_t   cnt_q;

    assign ready_o     = (state_q == S_IDLE);
    assign load_o      = ready_o && req_i && !flush_i;
    // one step per cycle until the count runs out
    assign step_o      = (state_q == S_DIVIDE) && (cnt_q != '0);
    assign fix_o       = (state_q == S_FIX);
    assign res_valid_o = (state_q == S_DONE);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            S_IDLE: begin
                if (load_o) begin
                    state_d = S_DIVIDE;
                end
            end
            S_DIVIDE: begin
                if (cnt_q == '0) begin
                    state_d = S_FIX;
                end
            end
            S_FIX: begin
                state_d = S_DONE;
            end
            S_DONE: begin
                if (res_accept_i) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
        // flush drops whatever is in flight
        if (flush_i) begin
            state_d = S_IDLE;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (load_o) begin
                cnt_q <= exu_pkg::div_cnt_t'(exu_pkg::DIV_ITER);
            end else if (step_o) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* exu_div_datapath.sv */
`default_nettype none

module exu_div_datapath (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                load_i,
    input  logic                                step_i,
    input  logic                                fix_i,
    input  exu_pkg::div_op_e                    op_i,
    input  logic [exu_pkg::XLEN-1:0]            op1_i,
    input  logic [exu_pkg::XLEN-1:0]            op2_i,
    input  logic [exu_pkg::REG_ADDR_WIDTH-1:0]  rd_i,
    input  logic [exu_pkg::COMMIT_ID_WIDTH-1:0] commit_id_i,
    input  logic                                valid_i,
    exu_result_if.unit                          res
);
    logic                                in_signed;
    logic                                in_neg1;
    logic                                in_neg2;
    logic                                is_rem;
    logic                                neg1_q;
    logic                                neg2_q;
    logic                                div_zero_q;
    logic                                overflow_q;
    exu_pkg::div_op_e                    op_q;
    logic [exu_pkg::XLEN-1:0]            dividend_q;
    logic [exu_pkg::XLEN-1:0]            divisor_q;
    logic [exu_pkg::XLEN-1:0]            quo_q;
    logic [exu_pkg::XLEN-1:0]            rem_q;
    logic [exu_pkg::XLEN-1:0]            result_q;
    logic [exu_pkg::REG_ADDR_WIDTH-1:0]  rd_q;
    logic [exu_pkg::COMMIT_ID_WIDTH-1:0] cid_q;
    logic [exu_pkg::XLEN:0]              rem_shift;
    logic [exu_pkg::XLEN:0]              rem_diff;
    logic [exu_pkg::XLEN-1:0]            quo_fix;
    logic [exu_pkg::XLEN-1:0]            rem_fix;
    logic [exu_pkg::XLEN-1:0]            result;

    assign in_signed = (op_i == exu_pkg::DIV_DIV) || (op_i == exu_pkg::DIV_REM);
    assign in_neg1   = in_signed && op1_i[exu_pkg::XLEN-1];
    assign in_neg2   = in_signed && op2_i[exu_pkg::XLEN-1];

    // op and special-case flags
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_q       <= exu_pkg::DIV_DIV;
            neg1_q     <= 1'b0;
            neg2_q     <= 1'b0;
            div_zero_q <= 1'b0;
            overflow_q <= 1'b0;
        end else if (load_i) begin
            op_q       <= op_i;
            neg1_q     <= in_neg1;
            neg2_q     <= in_neg2;
            div_zero_q <= (op2_i == '0);
            overflow_q <= in_signed && (op1_i == {1'b1, {(exu_pkg::XLEN-1){1'b0}}})
                          && (op2_i == '1);
        end
    end

    // restoring step, borrow out of the top bit means no subtract
    assign rem_shift = {rem_q, quo_q[exu_pkg::XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (load_i) begin
            dividend_q <= op1_i;
            divisor_q  <= in_neg2 ? -op2_i : op2_i;
            quo_q      <= in_neg1 ? -op1_i : op1_i;
            rem_q      <= '0;
            rd_q       <= rd_i;
            cid_q      <= commit_id_i;
        end else if (step_i) begin
            rem_q <= rem_diff[exu_pkg::XLEN] ? rem_shift[exu_pkg::XLEN-1:0]
                                             : rem_diff[exu_pkg::XLEN-1:0];
            quo_q <= {quo_q[exu_pkg::XLEN-2:0], !rem_diff[exu_pkg::XLEN]};
        end
        if (fix_i) begin
            result_q <= result;
        end
    end

    assign is_rem  = (op_q == exu_pkg::DIV_REM) || (op_q == exu_pkg::DIV_REMU);
    assign quo_fix = (neg1_q ^ neg2_q) ? -quo_q : quo_q;
    // remainder takes the sign of the dividend
    assign rem_fix = neg1_q ? -rem_q : rem_q;

    always_comb begin
        if (div_zero_q) begin
            result = is_rem ? dividend_q : '1;
        end else if (overflow_q) begin
            result = is_rem ? '0 : dividend_q;
        end else begin
            result = is_rem ? rem_fix : quo_fix;
        end
    end

    assign res.valid = valid_i;
    assign res.data  = {result_q, rd_q, cid_q};

endmodule

`default_nettype wire

/* exu_credit_counter.sv */
`default_nettype none

module exu_credit_counter #(
    parameter int unsigned WB_CREDITS = 2
) (
    input  logic clk,
    input  logic arst_n_i,
    input  logic spend_i,
    input  logic return_i,
    output logic has_credit_o
);
    localparam int unsigned CNT_WIDTH = $clog2(WB_CREDITS + 1);

    logic [CNT_WIDTH-1:0] cnt_q;

    // full credit after reset, spend and return together cancel
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= CNT_WIDTH'(WB_CREDITS);
        end else begin
            unique case ({spend_i, return_i})
                2'b10:   cnt_q <= cnt_q - 1'b1;
                2'b01:   cnt_q <= cnt_q + 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    assign has_credit_o = (cnt_q != '0);

endmodule

`default_nettype wire

/* exu_wb_arbiter.sv */
`default_nettype none

module exu_wb_arbiter (
    exu_result_if.arb                            alu_res,
    exu_result_if.arb                            div_res,
    input  logic                                 has_credit_i,
    output logic                                 wb_valid_o,
    output logic [exu_pkg::XLEN-1:0]             wb_wdata_o,
    output logic [exu_pkg::REG_ADDR_WIDTH-1:0]   wb_waddr_o,
    output logic [exu_pkg::COMMIT_ID_WIDTH-1:0]  wb_commit_id_o
);
    logic         div_sel;
    logic         alu_sel;
    exu_pkg::wb_t sel_rec;

    // divider result is always the older one, so it wins
    assign div_sel = has_credit_i && div_res.valid;
    assign alu_sel = has_credit_i && alu_res.valid && !div_res.valid;

    assign div_res.accept = div_sel;
    assign alu_res.accept = alu_sel;

    assign sel_rec = div_sel ? div_res.data : alu_res.data;

    // also the credit spend strobe
    assign wb_valid_o     = div_sel || alu_sel;
    assign wb_wdata_o     = sel_rec.wdata;
    assign wb_waddr_o     = sel_rec.waddr;
    assign wb_commit_id_o = sel_rec.commit_id;

endmodule

`default_nettype wire

/* exu_top.sv */
`default_nettype none

module exu_top #(
    parameter int unsigned WB_CREDITS = 2
) (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  logic                                 flush_i,

    // alu request
    input  logic                                 alu_req_i,
    input  exu_pkg::alu_op_e                     alu_op_i,
    input  logic [exu_pkg::XLEN-1:0]             alu_op1_i,
    input  logic [exu_pkg::XLEN-1:0]             alu_op2_i,
    input  logic [exu_pkg::REG_ADDR_WIDTH-1:0]   alu_rd_i,
    input  logic [exu_pkg::COMMIT_ID_WIDTH-1:0]  alu_commit_id_i,
    output logic                                 alu_ready_o,

    // divider request
    input  logic                                 div_req_i,
    input  exu_pkg::div_op_e                     div_op_i,
    input  logic [exu_pkg::XLEN-1:0]             div_op1_i,
    input  logic [exu_pkg::XLEN-1:0]             div_op2_i,
    input  logic [exu_pkg::REG_ADDR_WIDTH-1:0]   div_rd_i,
    input  logic [exu_pkg::COMMIT_ID_WIDTH-1:0]  div_commit_id_i,
    output logic                                 div_ready_o,

    // writeback port, credit based
    input  logic                                 wb_credit_i,
    output logic                                 wb_valid_o,
    output logic [exu_pkg::XLEN-1:0]             wb_wdata_o,
    output logic [exu_pkg::REG_ADDR_WIDTH-1:0]   wb_waddr_o,
    output logic [exu_pkg::COMMIT_ID_WIDTH-1:0]  wb_commit_id_o
);
    logic div_load;
    logic div_step;
    logic div_fix;
    logic div_res_valid;
    logic has_credit;

    exu_result_if alu_res_if (.clk(clk));
    exu_result_if div_res_if (.clk(clk));

    exu_alu u_alu (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .req_i       (alu_req_i),
        .op_i        (alu_op_i),
        .op1_i       (alu_op1_i),
        .op2_i       (alu_op2_i),
        .rd_i        (alu_rd_i),
        .commit_id_i (alu_commit_id_i),
        .ready_o     (alu_ready_o),
        .res         (alu_res_if.unit)
    );

    exu_div_fsm u_div_fsm (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .req_i        (div_req_i),
        .ready_o      (div_ready_o),
        .load_o       (div_load),
        .step_o       (div_step),
        .fix_o        (div_fix),
        .res_valid_o  (div_res_valid),
        .res_accept_i (div_res_if.accept)
    );

    exu_div_datapath u_div_datapath (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .load_i      (div_load),
        .step_i      (div_step),
        .fix_i       (div_fix),
        .op_i        (div_op_i),
        .op1_i       (div_op1_i),
        .op2_i       (div_op2_i),
        .rd_i        (div_rd_i),
        .commit_id_i (div_commit_id_i),
        .valid_i     (div_res_valid),
        .res         (div_res_if.unit)
    );

    exu_credit_counter #(
        .WB_CREDITS (WB_CREDITS)
    ) u_credit_counter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .spend_i      (wb_valid_o),
        .return_i     (wb_credit_i),
        .has_credit_o (has_credit)
    );

    exu_wb_arbiter u_wb_arbiter (
        .alu_res        (alu_res_if.arb),
        .div_res        (div_res_if.arb),
        .has_credit_i   (has_credit),
        .wb_valid_o     (wb_valid_o),
        .wb_wdata_o     (wb_wdata_o),
        .wb_waddr_o     (wb_waddr_o),
        .wb_commit_id_o (wb_commit_id_o)
    );

endmodule

`default_nettype wire

/* tb_exu.sv */
`default_nettype none

module tb_exu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WB_CREDITS = 2;
    localparam int XLEN       = exu_pkg::XLEN;
    localparam int N_IDS      = 2 ** exu_pkg::COMMIT_ID_WIDTH;
    localparam int N_ALU      = 40;
    localparam int N_DIV      = 16;
    localparam int N_OPS      = N_ALU + N_DIV + 7;
    localparam int TIMEOUT_CYCLES = N_OPS * (exu_pkg::DIV_ITER + 10) + 200;

    logic clk = 1'b0;
    logic arst_n_i;
    logic flush_i;
    logic alu_req_i;
    exu_pkg::alu_op_e alu_op_i;
    logic [XLEN-1:0] alu_op1_i;
    logic [XLEN-1:0] alu_op2_i;
    logic [exu_pkg::REG_ADDR_WIDTH-1:0] alu_rd_i;
    logic [exu_pkg::COMMIT_ID_WIDTH-1:0] alu_commit_id_i;
    logic alu_ready_o;
    logic div_req_i;
    exu_pkg::div_op_e div_op_i;
    logic [XLEN-1:0] div_op1_i;
    logic [XLEN-1:0] div_op2_i;
    logic [exu_pkg::REG_ADDR_WIDTH-1:0] div_rd_i;
    logic [exu_pkg::COMMIT_ID_WIDTH-1:0] div_commit_id_i;
    logic div_ready_o;
    logic wb_credit_i = 1'b0;
    logic wb_valid_o;
    logic [XLEN-1:0] wb_wdata_o;
    logic [exu_pkg::REG_ADDR_WIDTH-1:0] wb_waddr_o;
    logic [exu_pkg::COMMIT_ID_WIDTH-1:0] wb_commit_id_o;

    // reference model state
    exu_pkg::wb_t exp_tbl [N_IDS];
    logic [N_IDS-1:0] outstanding = '0;
    logic [XLEN-1:0] exp_wdata;
    logic [exu_pkg::REG_ADDR_WIDTH-1:0] exp_waddr;
    logic div_busy = 1'b0;
    logic hold = 1'b0;
    logic [2:0] alu_tag = '0;
    logic [2:0] div_tag = '0;
    logic [31:0] rng = 32'd33;
    int credits = WB_CREDITS;
    int owed = 0;
    int ret_wait = 0;
    int err_cnt = 0;
    int wb_cnt = 0;
    int req_cnt = 0;
    int cycle_cnt = 0;

    exu_top #(
        .WB_CREDITS (WB_CREDITS)
    ) i_dut (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .alu_req_i       (alu_req_i),
        .alu_op_i        (alu_op_i),
        .alu_op1_i       (alu_op1_i),
        .alu_op2_i       (alu_op2_i),
        .alu_rd_i        (alu_rd_i),
        .alu_commit_id_i (alu_commit_id_i),
        .alu_ready_o     (alu_ready_o),
        .div_req_i       (div_req_i),
        .div_op_i        (div_op_i),
        .div_op1_i       (div_op1_i),
        .div_op2_i       (div_op2_i),
        .div_rd_i        (div_rd_i),
        .div_commit_id_i (div_commit_id_i),
        .div_ready_o     (div_ready_o),
        .wb_credit_i     (wb_credit_i),
        .wb_valid_o      (wb_valid_o),
        .wb_wdata_o      (wb_wdata_o),
        .wb_waddr_o      (wb_waddr_o),
        .wb_commit_id_o  (wb_commit_id_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng ^ (rng >> 15);
    endfunction

    function automatic logic [XLEN-1:0] corner(input int i);
        case (i % 6)
            0: return '0;
            1: return 32'd1;
            2: return '1;
            3: return 32'h8000_0000;
            4: return 32'h7fff_ffff;
            default: return next_random();
        endcase
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input exu_pkg::alu_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (op)
            exu_pkg::ALU_ADD:  return a + b;
            exu_pkg::ALU_SUB:  return a - b;
            exu_pkg::ALU_AND:  return a & b;
            exu_pkg::ALU_OR:   return a | b;
            exu_pkg::ALU_XOR:  return a ^ b;
            exu_pkg::ALU_SLL:  return a << b[4:0];
            exu_pkg::ALU_SRL:  return a >> b[4:0];
            exu_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            exu_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            default:           return {31'b0, a < b};
        endcase
    endfunction

    // RISC-V division rules with zero divisor and signed overflow first
    function automatic logic [XLEN-1:0] div_ref(input exu_pkg::div_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        sa = a;
        sb = b;
        if (b == '0) begin
            return (op == exu_pkg::DIV_DIV || op == exu_pkg::DIV_DIVU) ? '1 : a;
        end
        if (op == exu_pkg::DIV_DIV && a == 32'h8000_0000 && b == '1) begin
            return a;
        end
        if (op == exu_pkg::DIV_REM && a == 32'h8000_0000 && b == '1) begin
            return '0;
        end
        case (op)
            exu_pkg::DIV_DIV:  return sa / sb;
            exu_pkg::DIV_DIVU: return a / b;
            exu_pkg::DIV_REM:  return sa % sb;
            default:           return a % b;
        endcase
    endfunction

    // expected record, credits and returned credits per rising edge
    always @(posedge clk) begin : model
        logic [N_IDS-1:0] next_out;
        int owed_now;
        if (!arst_n_i) begin
            outstanding <= '0;
            credits     <= WB_CREDITS;
            owed        <= 0;
            ret_wait    <= 0;
            div_busy    <= 1'b0;
            wb_credit_i <= 1'b0;
        end else begin
            next_out = outstanding;
            owed_now = owed + int'(wb_valid_o) - int'(wb_credit_i);
            if (wb_valid_o) begin
                next_out[wb_commit_id_o] = 1'b0;
                wb_cnt <= wb_cnt + 1;
                if (wb_commit_id_o[3]) begin
                    div_busy <= 1'b0;
                end
            end
            if (alu_req_i && alu_ready_o && !flush_i) begin
                next_out[alu_commit_id_i] = 1'b1;
                exp_tbl[alu_commit_id_i] <= {alu_ref(alu_op_i, alu_op1_i, alu_op2_i),
                                             alu_rd_i, alu_commit_id_i};
            end
            if (div_req_i && div_ready_o && !flush_i) begin
                next_out[div_commit_id_i] = 1'b1;
                exp_tbl[div_commit_id_i] <= {div_ref(div_op_i, div_op1_i, div_op2_i),
                                             div_rd_i, div_commit_id_i};
                div_busy <= 1'b1;
            end
            // flush drops everything taken so far
            if (flush_i) begin
                next_out = '0;
                div_busy <= 1'b0;
            end
            outstanding <= next_out;
            credits     <= credits - int'(wb_valid_o) + int'(wb_credit_i);
            owed        <= owed_now;
            wb_credit_i <= 1'b0;
            if (ret_wait > 0) begin
                ret_wait <= ret_wait - 1;
            end else if (!hold && owed_now > 0) begin
                wb_credit_i <= 1'b1;
                ret_wait    <= int'(next_random() % 6);
            end
        end
    end

    assign exp_wdata = exp_tbl[wb_commit_id_o].wdata;
    assign exp_waddr = exp_tbl[wb_commit_id_o].waddr;

    a_reset_state: assert property (@(posedge clk)
        !arst_n_i || $rose(arst_n_i) |-> !wb_valid_o && alu_ready_o && div_ready_o)
    else begin
        err_cnt++;
        $display("Fail %0t wb_valid_o,alu_ready_o,div_ready_o expected 011 got %b%b%b",
                 $time, $sampled(wb_valid_o), $sampled(alu_ready_o), $sampled(div_ready_o));
    end

    a_wb_expected: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_o |-> outstanding[wb_commit_id_o])
    else begin
        err_cnt++;
        $display("writeback at %0t for commit id %0d which has no pending request",
                 $time, $sampled(wb_commit_id_o));
    end

    a_wdata: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_o |-> wb_wdata_o == exp_wdata)
    else begin
        err_cnt++;
        $display("Fail %0t wb_wdata_o expected %h got %h",
                 $time, $sampled(exp_wdata), $sampled(wb_wdata_o));
    end

    a_waddr: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_o |-> wb_waddr_o == exp_waddr)
    else begin
        err_cnt++;
        $display("Fail %0t wb_waddr_o expected %0d got %0d",
                 $time, $sampled(exp_waddr), $sampled(wb_waddr_o));
    end

    a_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_o |-> credits != 0)
    else begin
        err_cnt++;
        $display("writeback at %0t while no credit was held", $time);
    end

    a_div_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        div_busy |-> !div_ready_o)
    else begin
        err_cnt++;
        $display("Fail %0t div_ready_o expected 0 got %b", $time, $sampled(div_ready_o));
    end

    a_flush_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> alu_ready_o && div_ready_o)
    else begin
        err_cnt++;
        $display("Fail %0t alu_ready_o,div_ready_o expected 11 got %b%b",
                 $time, $sampled(alu_ready_o), $sampled(div_ready_o));
    end

    task automatic alu_issue(input exu_pkg::alu_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
        alu_req_i       <= 1'b1;
        alu_op_i        <= op;
        alu_op1_i       <= a;
        alu_op2_i       <= b;
        alu_rd_i        <= exu_pkg::REG_ADDR_WIDTH'(next_random());
        alu_commit_id_i <= {1'b0, alu_tag};
        @(posedge clk);
        while (!alu_ready_o) begin
            @(posedge clk);
        end
        alu_req_i <= 1'b0;
        alu_tag = alu_tag + 1'b1;
        req_cnt++;
    endtask

    task automatic div_issue(input exu_pkg::div_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
        div_req_i       <= 1'b1;
        div_op_i        <= op;
        div_op1_i       <= a;
        div_op2_i       <= b;
        div_rd_i        <= exu_pkg::REG_ADDR_WIDTH'(next_random());
        div_commit_id_i <= {1'b1, div_tag};
        @(posedge clk);
        while (!div_ready_o) begin
            @(posedge clk);
        end
        div_req_i <= 1'b0;
        div_tag = div_tag + 1'b1;
        req_cnt++;
    endtask

    task automatic run_alu(input int n);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int i = 0; i < n; i++) begin
            a = (i % 3 == 0) ? corner(i) : next_random();
            b = (i % 4 == 1) ? corner(i + 2) : next_random();
            alu_issue(exu_pkg::alu_op_e'(i % 10), a, b);
        end
    endtask

    // first eight cover divide by zero and signed overflow on every op
    // next four use a negative divisor
    task automatic run_div(input int n);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int i = 0; i < n; i++) begin
            a = (i >= 4 && i < 8) ? 32'h8000_0000 : next_random();
            b = next_random() >> (i % 24);
            if (i < 4) begin
                b = '0;
            end else if (i < 8) begin
                b = '1;
            end else if (i < 12) begin
                b = -b;
            end
            div_issue(exu_pkg::div_op_e'(i % 4), a, b);
        end
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (outstanding != '0 || owed != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with results still pending", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        arst_n_i        = 1'b1;
        flush_i         = 1'b0;
        alu_req_i       = 1'b0;
        alu_op_i        = exu_pkg::ALU_ADD;
        alu_op1_i       = '0;
        alu_op2_i       = '0;
        alu_rd_i        = '0;
        alu_commit_id_i = '0;
        div_req_i       = 1'b0;
        div_op_i        = exu_pkg::DIV_DIV;
        div_op1_i       = '0;
        div_op2_i       = '0;
        div_rd_i        = '0;
        div_commit_id_i = '0;
        #1 arst_n_i = 1'b0;
        repeat (17) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        fork
            run_alu(N_ALU);
            run_div(N_DIV);
        join
        wait_idle();
        // credits withheld so results wait in the units
        hold <= 1'b1;
        fork
            begin
                alu_issue(exu_pkg::ALU_ADD, next_random(), next_random());
                alu_issue(exu_pkg::ALU_SRA, corner(3), next_random());
            end
            div_issue(exu_pkg::DIV_REM, next_random(), next_random() >> 7);
        join
        repeat (60) @(posedge clk);
        hold <= 1'b0;
        wait_idle();
        // alu slot full and divider busy when the flush hits
        hold <= 1'b1;
        alu_issue(exu_pkg::ALU_SUB, next_random(), next_random());
        alu_issue(exu_pkg::ALU_SLTU, next_random(), next_random());
        alu_issue(exu_pkg::ALU_OR, next_random(), next_random());
        div_issue(exu_pkg::DIV_DIVU, next_random(), next_random() >> 3);
        repeat (5) @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        hold    <= 1'b0;
        repeat (exu_pkg::DIV_ITER + 10) @(posedge clk);
        wait_idle();
        $display("errors %0d, requests %0d, writebacks %0d", err_cnt, req_cnt, wb_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
exu_pkg.sv
exu_result_if.sv
exu_alu.sv
exu_div_fsm.sv
exu_div_datapath.sv
exu_credit_counter.sv
exu_wb_arbiter.sv
exu_top.sv
tb_exu.sv
